// ==== all.f ====
logic/csr_pkg.sv
logic/hpm_counter_bank.sv
logic/csr_file.sv
logic/csr_access_arbiter.sv
logic/csr_unit_top.sv
dv/csr_unit_assertions.sv
dv/csr_unit_tb.sv

// ==== dv/csr_unit_assertions.sv ====
`timescale 1ns/10ps

module csr_unit_assertions import csr_pkg::*; (
    input logic        clk,
    input logic        core_en,
    input logic        core_re,
    input logic        host_req,
    input logic        host_gnt,
    input arch_width_t core_rdata
);

    int unsigned err_count = 0;

    // core always wins the access path
    gnt_yields_to_core: assert property (@(posedge clk) core_en |-> !host_gnt)
        else begin
            err_count++;
            $error("host_gnt high while core_en is high");
        end

    gnt_needs_req: assert property (@(posedge clk) host_gnt |-> host_req)
        else begin
            err_count++;
            $error("host_gnt high without host_req");
        end

    core_rdata_quiet: assert property (@(posedge clk) !(core_en && core_re) |-> core_rdata == '0)
        else begin
            err_count++;
            $error("core_rdata nonzero without a core read");
        end

endmodule

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/10ps

module csr_unit_tb import csr_pkg::*; ();

    localparam int unsigned CLOCK_FREQ = 4_000_000;
    localparam int unsigned CLOCKS_PER_US = CLOCK_FREQ / 1_000_000;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int TIME_READS = 14;
    localparam int NUM_REG_OPS = 24;
    localparam int MCYCLE_TRIALS = 4;
    localparam int RETIRE_CYCLES = 32;
    localparam int PERF_CYCLES = 48;
    // worst case cycles per test, summed
    localparam int TEST_CYCLES = RESET_CYCLES + TIME_READS + 2 * NUM_REG_OPS
        + 17 * MCYCLE_TRIALS + RETIRE_CYCLES + 3 + 3 * MHPMCOUNTERS + PERF_CYCLES
        + 2 * MHPMCOUNTERS + 12;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        core_en;
    arch_width_t core_inst;
    arch_width_t core_rs1;
    logic        core_re;
    logic        core_we;
    csr_op_t     core_op;
    logic        core_ui;
    logic        host_req;
    logic        host_we;
    csr_addr_t   host_addr;
    arch_width_t host_wdata;
    logic        retire;
    perf_event_t perf_event;
    arch_width_t core_rdata;
    logic        host_gnt;
    arch_width_t host_rdata;

    // expectations handed to the compare process
    logic        core_chk;
    logic        time_chk;
    arch_width_t exp_core;
    arch_width_t exp_host;
    logic        exp_gnt;

    int unsigned edge_count = 0;
    logic [15:0] lfsr_state = 16'd9;
    arch_width_t model_mscratch;
    arch_width_t model_tohost;

    csr_unit_top #(
        .CLOCK_FREQ (CLOCK_FREQ)
    ) csr_unit_top_inst (
        .clk        (clk),
        .rst        (rst),
        .core_en    (core_en),
        .core_inst  (core_inst),
        .core_rs1   (core_rs1),
        .core_re    (core_re),
        .core_we    (core_we),
        .core_op    (core_op),
        .core_ui    (core_ui),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .retire     (retire),
        .perf_event (perf_event),
        .core_rdata (core_rdata),
        .host_gnt   (host_gnt),
        .host_rdata (host_rdata)
    );

    bind csr_access_arbiter csr_unit_assertions arb_assert_inst (
        .clk        (csr_unit_tb.clk),
        .core_en    (core_en),
        .core_re    (core_re),
        .host_req   (host_req),
        .host_gnt   (host_gnt),
        .core_rdata (core_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // edges since reset release feed the time reference
    always @(posedge clk) begin
        if (rst) begin
            edge_count <= 0;
        end else begin
            edge_count <= edge_count + 1;
        end
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        lfsr_step = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic arch_width_t rand_bits(input int n);
        arch_width_t val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic arch_width_t ref_rmw(input csr_op_t op, input arch_width_t old_val,
                                            input arch_width_t src);
        case (op)
            CSR_OP_RW: ref_rmw = src;
            CSR_OP_RS: ref_rmw = old_val | src;
            CSR_OP_RC: ref_rmw = old_val & ~src;
            default:   ref_rmw = old_val;
        endcase
    endfunction

    // time steps on edge 4n+1 after reset release
    function automatic arch_width_t ref_time(input int unsigned edges);
        ref_time = (edges == 0) ? '0 : arch_width_t'((edges - 1) / CLOCKS_PER_US);
    endfunction

    // codes 1..6 pick event bits 0..5
    function automatic logic event_selected(input logic [2:0] code, input perf_event_t pe);
        event_selected = (code >= 3'd1 && code <= 3'd6) ? pe[code - 3'd1] : 1'b0;
    endfunction

    task automatic check(input string name, input arch_width_t got, input arch_width_t exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    always @(negedge clk) begin
        if (core_chk) begin
            check("core_rdata", core_rdata, exp_core);
        end
        if (time_chk) begin
            check("time", core_rdata, ref_time(edge_count));
        end
        check("host_gnt", arch_width_t'(host_gnt), arch_width_t'(exp_gnt));
        check("host_rdata", host_rdata, exp_host);
        if (csr_unit_top_inst.csr_access_arbiter_inst.arb_assert_inst.err_count != 0) begin
            $display("a bound assertion on the arbiter failed at %0t", $time);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic core_access(input csr_addr_t addr, input csr_op_t op, input logic ui,
                               input arch_width_t src, input logic we, input logic chk,
                               input arch_width_t exp);
        @(posedge clk);
        core_en <= 1'b1;
        core_re <= 1'b1;
        core_we <= we;
        core_op <= op;
        core_ui <= ui;
        core_inst <= {addr, src[4:0], 15'h0073};
        // rs1 kept apart from the immediate field
        core_rs1 <= ui ? ~src : src;
        core_chk <= chk;
        exp_core <= exp;
        time_chk <= 1'b0;
    endtask

    task automatic core_read(input csr_addr_t addr, input arch_width_t exp);
        core_access(addr, CSR_OP_NONE, 1'b0, '0, 1'b0, 1'b1, exp);
    endtask

    task automatic read_time();
        core_access(CSR_TIME, CSR_OP_NONE, 1'b0, '0, 1'b0, 1'b0, '0);
        time_chk <= 1'b1;
    endtask

    task automatic core_idle();
        @(posedge clk);
        core_en <= 1'b0;
        core_re <= 1'b0;
        core_we <= 1'b0;
        core_op <= CSR_OP_NONE;
        core_chk <= 1'b1;
        exp_core <= '0;
        time_chk <= 1'b0;
    endtask

    task automatic host_drive(input logic req, input logic we, input csr_addr_t addr,
                              input arch_width_t wdata, input logic gnt,
                              input arch_width_t exp);
        host_req <= req;
        host_we <= we;
        host_addr <= addr;
        host_wdata <= wdata;
        exp_gnt <= gnt;
        exp_host <= exp;
    endtask

    task automatic test_time();
        for (int i = 0; i < TIME_READS; i++) begin
            read_time();
        end
    endtask

    task automatic test_reg_ops();
        csr_addr_t   addr;
        csr_op_t     op;
        logic        ui;
        arch_width_t src;
        arch_width_t old_val;
        arch_width_t new_val;
        for (int i = 0; i < NUM_REG_OPS; i++) begin
            addr = (rand_bits(1) != '0) ? CSR_TOHOST : CSR_MSCRATCH;
            op = csr_op_t'(2'(rand_bits(2) % 3));
            ui = (rand_bits(1) != '0);
            src = rand_bits(32);
            old_val = (addr == CSR_TOHOST) ? model_tohost : model_mscratch;
            new_val = ref_rmw(op, old_val, ui ? arch_width_t'(src[4:0]) : src);
            // the access cycle itself shows the old value
            core_access(addr, op, ui, src, 1'b1, 1'b1, old_val);
            if (addr == CSR_TOHOST) begin
                model_tohost = new_val;
            end else begin
                model_mscratch = new_val;
            end
            core_read(addr, new_val);
        end
    endtask

    task automatic test_mcycle();
        arch_width_t val;
        int unsigned k;
        for (int t = 0; t < MCYCLE_TRIALS; t++) begin
            val = rand_bits(32);
            k = 1 + rand_bits(4);
            core_access(CSR_MCYCLE, CSR_OP_RW, 1'b0, val, 1'b1, 1'b0, '0);
            repeat (k - 1) core_idle();
            core_read(CSR_MCYCLE, val + arch_width_t'(k - 1));
        end
    endtask

    task automatic test_minstret();
        arch_width_t base;
        arch_width_t pulses;
        logic        pulse;
        base = rand_bits(32);
        pulses = '0;
        core_access(CSR_MINSTRET, CSR_OP_RW, 1'b0, base, 1'b1, 1'b0, '0);
        for (int i = 0; i < RETIRE_CYCLES; i++) begin
            core_idle();
            pulse = (rand_bits(1) != '0);
            retire <= pulse;
            if (pulse) begin
                pulses++;
            end
        end
        core_read(CSR_MINSTRET, base + pulses);
        retire <= 1'b0;
    endtask

    task automatic test_perf_counters();
        logic [2:0]  code [MHPMCOUNTERS];
        csr_dw_t     expect_cnt [MHPMCOUNTERS];
        perf_event_t pe;
        arch_width_t hi;
        for (int i = 0; i < MHPMCOUNTERS; i++) begin
            // last counter stays on NONE
            code[i] = (i == MHPMCOUNTERS - 1) ? 3'd0 : 3'(rand_bits(3) % 7);
            hi = rand_bits(32);
            expect_cnt[i] = {hi, 32'h0};
            core_access(csr_addr_t'(CSR_MHPMEVENT3 + i), CSR_OP_RW, 1'b0,
                        arch_width_t'(code[i]), 1'b1, 1'b1, '0);
            core_access(csr_addr_t'(CSR_MHPMCOUNTER3H + i), CSR_OP_RW, 1'b0, hi,
                        1'b1, 1'b1, '0);
            core_read(csr_addr_t'(CSR_MHPMEVENT3 + i), arch_width_t'(code[i]));
        end
        for (int c = 0; c < PERF_CYCLES; c++) begin
            core_idle();
            pe = perf_event_t'(rand_bits(6));
            perf_event <= pe;
            for (int i = 0; i < MHPMCOUNTERS; i++) begin
                if (event_selected(code[i], pe)) begin
                    expect_cnt[i] = expect_cnt[i] + 64'd1;
                end
            end
        end
        core_idle();
        perf_event <= '0;
        for (int i = 0; i < MHPMCOUNTERS; i++) begin
            core_read(csr_addr_t'(CSR_MHPMCOUNTER3 + i), expect_cnt[i][31:0]);
            core_read(csr_addr_t'(CSR_MHPMCOUNTER3H + i), expect_cnt[i][63:32]);
        end
    endtask

    task automatic test_arbitration();
        arch_width_t blocked;
        arch_width_t granted;
        blocked = rand_bits(32);
        granted = rand_bits(32);
        core_read(CSR_MSCRATCH, model_mscratch);
        host_drive(1'b1, 1'b1, CSR_MSCRATCH, blocked, 1'b0, '0);
        core_read(CSR_MSCRATCH, model_mscratch);
        // held request goes through once the core is idle
        core_idle();
        host_drive(1'b1, 1'b1, CSR_MSCRATCH, granted, 1'b1, model_mscratch);
        model_mscratch = granted;
        core_idle();
        host_drive(1'b1, 1'b0, CSR_MSCRATCH, '0, 1'b1, granted);
        core_idle();
        host_drive(1'b0, 1'b0, CSR_MSCRATCH, '0, 1'b0, '0);
        core_read(CSR_MSCRATCH, model_mscratch);
    endtask

    initial begin
        rst = 1'b1;
        core_en = 1'b0;
        core_inst = '0;
        core_rs1 = '0;
        core_re = 1'b0;
        core_we = 1'b0;
        core_op = CSR_OP_NONE;
        core_ui = 1'b0;
        host_req = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        retire = 1'b0;
        perf_event = '0;
        core_chk = 1'b1;
        time_chk = 1'b0;
        exp_core = '0;
        exp_host = '0;
        exp_gnt = 1'b0;
        model_mscratch = '0;
        model_tohost = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        test_time();
        test_reg_ops();
        test_mcycle();
        test_minstret();
        test_perf_counters();
        test_arbitration();
        read_time();
        core_read(CSR_TIMEH, '0);
        core_idle();
        core_idle();
        if (csr_unit_top_inst.csr_access_arbiter_inst.arb_assert_inst.err_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("bound assertions on the arbiter failed");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== logic/csr_access_arbiter.sv ====
`timescale 1ns/10ps

module csr_access_arbiter import csr_pkg::*; (
    input  logic        core_en,
    input  logic        core_re,
    input  logic        core_we,
    input  csr_op_t     core_op,
    input  logic        core_ui,
    input  arch_width_t core_inst,
    input  arch_width_t core_rs1,
    input  logic        host_req,
    input  logic        host_we,
    input  csr_addr_t   host_addr,
    input  arch_width_t host_wdata,
    input  arch_width_t rdata,
    output logic        host_gnt,
    output arch_width_t core_rdata,
    output arch_width_t host_rdata,
    output logic        acc_re,
    output logic        acc_we,
    output csr_op_t     acc_op,
    output csr_addr_t   acc_addr,
    output arch_width_t acc_src
);

    arch_width_t imm;
    arch_width_t core_src;

    // core never stalls, so the host only gets idle cycles
    assign host_gnt = host_req && !core_en;

    assign imm = {{(ARCH_WIDTH-5){1'b0}}, core_inst[19:15]};
    assign core_src = core_ui ? imm : core_rs1;

    always_comb begin
        acc_re = 1'b0;
        acc_we = 1'b0;
        acc_op = CSR_OP_NONE;
        acc_addr = '0;
        acc_src = '0;
        if (core_en) begin
            acc_re = core_re;
            acc_we = core_we;
            acc_op = core_op;
            acc_addr = core_inst[31:20];
            acc_src = core_src;
        end else if (host_gnt) begin
            // host always reads, and writes are plain overwrites
            acc_re = 1'b1;
            acc_we = host_we;
            acc_op = CSR_OP_RW;
            acc_addr = host_addr;
            acc_src = host_wdata;
        end
    end

    assign core_rdata = (core_en && core_re) ? rdata : '0;
    assign host_rdata = host_gnt ? rdata : '0;

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/10ps

module csr_file import csr_pkg::*; #(
    parameter int unsigned CLOCK_FREQ = 100_000_000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        acc_re,
    input  logic        acc_we,
    input  csr_op_t     acc_op,
    input  csr_addr_t   acc_addr,
    input  arch_width_t acc_src,
    input  logic        retire,
    input  perf_event_t perf_event,
    output arch_width_t rdata
);

    localparam int unsigned CLOCKS_PER_US = CLOCK_FREQ / 1_000_000;
    localparam int unsigned CNT_WIDTH = (CLOCKS_PER_US > 1) ? $clog2(CLOCKS_PER_US) : 1;

    arch_width_t tohost;
    arch_width_t mscratch;
    csr_dw_t     mcycle;
    csr_dw_t     minstret;
    csr_dw_t     mtime;

    arch_width_t own_rdata;
    arch_width_t hpm_rdata;
    arch_width_t wdata;
    logic        wr_en;

    logic                 tick_us;
    logic [CNT_WIDTH-1:0] cnt_us;

    // read mux
    always_comb begin
        own_rdata = '0;
        case (acc_addr)
            CSR_TOHOST:    own_rdata = tohost;
            CSR_MSCRATCH:  own_rdata = mscratch;
            CSR_MCYCLE:    own_rdata = mcycle[31:0];
            CSR_MCYCLEH:   own_rdata = mcycle[63:32];
            CSR_MINSTRET:  own_rdata = minstret[31:0];
            CSR_MINSTRETH: own_rdata = minstret[63:32];
            CSR_TIME:      own_rdata = mtime[31:0];
            CSR_TIMEH:     own_rdata = mtime[63:32];
            default:       own_rdata = '0;
        endcase
    end

    // bank returns 0 outside its own range
    assign rdata = acc_re ? (own_rdata | hpm_rdata) : '0;

    // read-modify-write
    always_comb begin
        case (acc_op)
            CSR_OP_RW: wdata = acc_src;
            CSR_OP_RS: wdata = rdata | acc_src;
            CSR_OP_RC: wdata = rdata & ~acc_src;
            default:   wdata = '0;
        endcase
    end

    assign wr_en = acc_we && (acc_op != CSR_OP_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            tohost <= '0;
            mscratch <= '0;
        end else if (wr_en) begin
            case (acc_addr)
                CSR_TOHOST:   tohost <= wdata;
                CSR_MSCRATCH: mscratch <= wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
        end else if (wr_en && (acc_addr == CSR_MCYCLE)) begin
            mcycle[31:0] <= wdata;
        end else if (wr_en && (acc_addr == CSR_MCYCLEH)) begin
            mcycle[63:32] <= wdata;
        end else begin
            mcycle <= mcycle + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (wr_en && (acc_addr == CSR_MINSTRET)) begin
            minstret[31:0] <= wdata;
        end else if (wr_en && (acc_addr == CSR_MINSTRETH)) begin
            minstret[63:32] <= wdata;
        end else if (retire) begin
            minstret <= minstret + 64'd1;
        end
    end

    // microsecond prescaler, tick is registered
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_us <= '0;
            tick_us <= 1'b0;
        end else if (cnt_us == CNT_WIDTH'(CLOCKS_PER_US - 1)) begin
            cnt_us <= '0;
            tick_us <= 1'b1;
        end else begin
            cnt_us <= cnt_us + 1'b1;
            tick_us <= 1'b0;
        end
    end

    // read only, writes dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else if (tick_us) begin
            mtime <= mtime + 64'd1;
        end
    end

    hpm_counter_bank hpm_counter_bank_inst (
        .clk        (clk),
        .rst        (rst),
        .addr       (acc_addr),
        .we         (wr_en),
        .wdata      (wdata),
        .perf_event (perf_event),
        .hpm_rdata  (hpm_rdata)
    );

endmodule

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    localparam int unsigned ARCH_WIDTH = 32;

    typedef logic [ARCH_WIDTH-1:0] arch_width_t;
    typedef logic [63:0] csr_dw_t;
    typedef logic [11:0] csr_addr_t;

    // one strobe per pipeline event
    // [0] bad spec, [1] back-end, [2] d-cache, [3] front-end, [4] i-cache, [5] simd retire
    typedef logic [5:0] perf_event_t;

    typedef enum logic [1:0] {
        CSR_OP_RW   = 2'd0,
        CSR_OP_RS   = 2'd1,
        CSR_OP_RC   = 2'd2,
        CSR_OP_NONE = 2'd3
    } csr_op_t;

    // codes 7 and up select nothing
    typedef enum logic [2:0] {
        MHPMEVENT_NONE     = 3'd0,
        MHPMEVENT_BAD_SPEC = 3'd1,
        MHPMEVENT_BE       = 3'd2,
        MHPMEVENT_BE_DC    = 3'd3,
        MHPMEVENT_FE       = 3'd4,
        MHPMEVENT_FE_IC    = 3'd5,
        MHPMEVENT_RET_SIMD = 3'd6
    } mhpmevent_t;

    localparam int unsigned MHPMCOUNTERS = 6;
    localparam int unsigned MHPM_OFFSET = 3;

    localparam csr_addr_t CSR_TOHOST = 12'h51E;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MCYCLE = 12'hB00;
    localparam csr_addr_t CSR_MCYCLEH = 12'hB80;
    localparam csr_addr_t CSR_MINSTRET = 12'hB02;
    localparam csr_addr_t CSR_MINSTRETH = 12'hB82;
    localparam csr_addr_t CSR_TIME = 12'hC01;
    localparam csr_addr_t CSR_TIMEH = 12'hC81;

    localparam csr_addr_t CSR_MHPMCOUNTER3 = 12'hB03;
    localparam csr_addr_t CSR_MHPMCOUNTER4 = 12'hB04;
    localparam csr_addr_t CSR_MHPMCOUNTER5 = 12'hB05;
    localparam csr_addr_t CSR_MHPMCOUNTER6 = 12'hB06;
    localparam csr_addr_t CSR_MHPMCOUNTER7 = 12'hB07;
    localparam csr_addr_t CSR_MHPMCOUNTER8 = 12'hB08;
    localparam csr_addr_t CSR_MHPMCOUNTER3H = 12'hB83;
    localparam csr_addr_t CSR_MHPMCOUNTER4H = 12'hB84;
    localparam csr_addr_t CSR_MHPMCOUNTER5H = 12'hB85;
    localparam csr_addr_t CSR_MHPMCOUNTER6H = 12'hB86;
    localparam csr_addr_t CSR_MHPMCOUNTER7H = 12'hB87;
    localparam csr_addr_t CSR_MHPMCOUNTER8H = 12'hB88;

    localparam csr_addr_t CSR_MHPMEVENT3 = 12'h323;
    localparam csr_addr_t CSR_MHPMEVENT4 = 12'h324;
    localparam csr_addr_t CSR_MHPMEVENT5 = 12'h325;
    localparam csr_addr_t CSR_MHPMEVENT6 = 12'h326;
    localparam csr_addr_t CSR_MHPMEVENT7 = 12'h327;
    localparam csr_addr_t CSR_MHPMEVENT8 = 12'h328;

endpackage

// ==== logic/csr_unit_top.sv ====
`timescale 1ns/10ps

module csr_unit_top import csr_pkg::*; #(
    parameter int unsigned CLOCK_FREQ = 100_000_000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        core_en,
    input  arch_width_t core_inst,
    input  arch_width_t core_rs1,
    input  logic        core_re,
    input  logic        core_we,
    input  csr_op_t     core_op,
    input  logic        core_ui,
    input  logic        host_req,
    input  logic        host_we,
    input  csr_addr_t   host_addr,
    input  arch_width_t host_wdata,
    input  logic        retire,
    input  perf_event_t perf_event,
    output arch_width_t core_rdata,
    output logic        host_gnt,
    output arch_width_t host_rdata
);

    logic        acc_re;
    logic        acc_we;
    csr_op_t     acc_op;
    csr_addr_t   acc_addr;
    arch_width_t acc_src;
    arch_width_t rdata;

    csr_access_arbiter csr_access_arbiter_inst (
        .core_en    (core_en),
        .core_re    (core_re),
        .core_we    (core_we),
        .core_op    (core_op),
        .core_ui    (core_ui),
        .core_inst  (core_inst),
        .core_rs1   (core_rs1),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rdata      (rdata),
        .host_gnt   (host_gnt),
        .core_rdata (core_rdata),
        .host_rdata (host_rdata),
        .acc_re     (acc_re),
        .acc_we     (acc_we),
        .acc_op     (acc_op),
        .acc_addr   (acc_addr),
        .acc_src    (acc_src)
    );

    csr_file #(
        .CLOCK_FREQ (CLOCK_FREQ)
    ) csr_file_inst (
        .clk        (clk),
        .rst        (rst),
        .acc_re     (acc_re),
        .acc_we     (acc_we),
        .acc_op     (acc_op),
        .acc_addr   (acc_addr),
        .acc_src    (acc_src),
        .retire     (retire),
        .perf_event (perf_event),
        .rdata      (rdata)
    );

endmodule

// ==== logic/hpm_counter_bank.sv ====
`timescale 1ns/10ps

module hpm_counter_bank import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  csr_addr_t   addr,
    input  logic        we,
    input  arch_width_t wdata,
    input  perf_event_t perf_event,
    output arch_width_t hpm_rdata
);

    localparam int unsigned IDX_W = $clog2(MHPMCOUNTERS);

    mhpmevent_t sel [MHPMCOUNTERS];
    csr_dw_t    cnt [MHPMCOUNTERS];

    logic             cnt_lo_hit;
    logic             cnt_hi_hit;
    logic             evt_hit;
    logic [IDX_W-1:0] idx;

    function automatic logic event_active(input perf_event_t pe, input mhpmevent_t code);
        case (code)
            MHPMEVENT_BAD_SPEC: event_active = pe[0];
            MHPMEVENT_BE:       event_active = pe[1];
            MHPMEVENT_BE_DC:    event_active = pe[2];
            MHPMEVENT_FE:       event_active = pe[3];
            MHPMEVENT_FE_IC:    event_active = pe[4];
            MHPMEVENT_RET_SIMD: event_active = pe[5];
            default:            event_active = 1'b0;
        endcase
    endfunction

    assign cnt_lo_hit = (addr >= CSR_MHPMCOUNTER3) && (addr <= CSR_MHPMCOUNTER8);
    assign cnt_hi_hit = (addr >= CSR_MHPMCOUNTER3H) && (addr <= CSR_MHPMCOUNTER8H);
    assign evt_hit = (addr >= CSR_MHPMEVENT3) && (addr <= CSR_MHPMEVENT8);

    // all three ranges share the low nibble numbering
    assign idx = IDX_W'(addr[3:0] - 4'(MHPM_OFFSET));

    always_comb begin
        hpm_rdata = '0;
        if (cnt_lo_hit) begin
            hpm_rdata = cnt[idx][31:0];
        end else if (cnt_hi_hit) begin
            hpm_rdata = cnt[idx][63:32];
        end else if (evt_hit) begin
            hpm_rdata = arch_width_t'(sel[idx]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MHPMCOUNTERS; i++) begin
                sel[i] <= MHPMEVENT_NONE;
            end
        end else if (we && evt_hit) begin
            sel[idx] <= mhpmevent_t'(wdata[2:0]);
        end
    end

    for (genvar i = 0; i < MHPMCOUNTERS; i++) begin : gen_cnt
        logic wr_lo;
        logic wr_hi;

        assign wr_lo = we && cnt_lo_hit && (idx == IDX_W'(i));
        assign wr_hi = we && cnt_hi_hit && (idx == IDX_W'(i));

        always_ff @(posedge clk) begin
            if (rst) begin
                cnt[i] <= '0;
            end else if (wr_lo) begin
                cnt[i][31:0] <= wdata;
            end else if (wr_hi) begin
                cnt[i][63:32] <= wdata;
            end else if (event_active(perf_event, sel[i])) begin
                cnt[i] <= cnt[i] + 64'd1;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module csr_unit_tb -f all.f -o csr_unit_sim \
    && ./obj_dir/csr_unit_sim > sim.log 2>&1
grep -qx "STATUS: PASS" sim.log && echo "csr_unit_tb passed" \
    || { echo "csr_unit_tb failed, see sim.log"; exit 1; }
